//--- hdl/fs_defs.svh
// Widths, pipeline depth, flag bit positions and opcode codes of the complex lane
// Included by the packages and by every RTL file that needs a constant
`ifndef FS_DEFS_SVH
`define FS_DEFS_SVH

// Datapath widths
`define SIZE_DATA            32   // Operand and result word
`define SIZE_IMMEDIATE       16   // Immediate field, carried only
`define SIZE_OPCODE_I        8    // Opcode field
`define SIZE_PHYSICAL_LOG    7    // Physical register tag
`define SIZE_ACTIVELIST_LOG  6    // Active-list index
`define EXECUTION_FLAGS      6    // Flag vector

// Stage registers behind the ALU, 1 or more
`define CALU_DEPTH           3

// Bit positions inside the flag vector
`define FLAG_BRANCH          5    // Never set by this lane
`define FLAG_WR_DEST         4    // Result goes to the register file
`define FLAG_WR_LOW          3    // Low half of a double-width op
`define FLAG_EXECUTED        2
`define FLAG_EXCEPTION       1    // Syscall trap
`define FLAG_MISPREDICT      0    // Always zero here

// Opcodes handled by the complex lane
`define MULT_L               8'h40  // Signed product, low word
`define MULT_H               8'h41  // Signed product, high word
`define MULTU_L              8'h42  // Unsigned product, low word
`define MULTU_H              8'h43  // Unsigned product, high word
`define DIV_L                8'h44  // Signed quotient
`define DIV_H                8'h45  // Signed remainder
`define DIVU_L               8'h46  // Unsigned quotient
`define DIVU_H               8'h47  // Unsigned remainder
`define SYSCALL              8'h48

`endif

//--- hdl/isa_pkg.sv
// Value types of the instruction set seen by the complex lane
// Ports of the ALU and the exec packet types are built from these
`default_nettype none

`include "fs_defs.svh"

package isa_pkg;

  // One operand or result word
  typedef logic [`SIZE_DATA-1:0] data_t;

  // Immediate, travels with the op but feeds no operation
  typedef logic [`SIZE_IMMEDIATE-1:0] imm_t;

  // Opcode as issued
  typedef logic [`SIZE_OPCODE_I-1:0] opcode_t;

  // Execution flags
  // bit 5 branch
  // bit 4 write destination
  // bit 3 write low half
  // bit 2 executed
  // bit 1 exception
  // bit 0 mispredict
  typedef logic [`EXECUTION_FLAGS-1:0] flags_t;

endpackage

`default_nettype wire

//--- hdl/exec_pkg.sv
// Tags and packets that move through the complex execution lane
// Issue payload in, one packet per stage, writeback and active-list packets out
`default_nettype none

`include "fs_defs.svh"

package exec_pkg;
  import isa_pkg::*;

  typedef logic [`SIZE_PHYSICAL_LOG-1:0]   phys_tag_t;  // Physical register tag
  typedef logic [`SIZE_ACTIVELIST_LOG-1:0] al_idx_t;    // Active-list slot

  // Issued op with operands already read
  typedef struct packed {
    opcode_t   opcode;
    data_t     data1;
    data_t     data2;
    imm_t      immd;       // Carried along, unused by the ALU
    phys_tag_t phys_dest;
    al_idx_t   al_idx;
  } issue_pkt_t;

  // Computed op in flight down the stage chain
  typedef struct packed {
    data_t     result;
    flags_t    flags;
    phys_tag_t phys_dest;
    al_idx_t   al_idx;
  } stage_pkt_t;

  // Writeback bus
  typedef struct packed {
    phys_tag_t phys_dest;
    data_t     data;
  } wb_pkt_t;

  // Active-list update
  typedef struct packed {
    al_idx_t al_idx;
    flags_t  flags;
  } ctrl_pkt_t;

endpackage

`default_nettype wire

//--- hdl/complex_alu.sv
// Combinational multiply, divide, remainder and syscall unit
// Gives one data word and the execution flags for the opcode, no latency
`default_nettype none
`timescale 1ns/100ps

`include "fs_defs.svh"

module complex_alu (
  input  isa_pkg::opcode_t opcode_i,
  input  isa_pkg::data_t   data1_i,
  input  isa_pkg::data_t   data2_i,
  output isa_pkg::data_t   result_o,
  output isa_pkg::flags_t  flags_o
);
  import isa_pkg::*;

  localparam flags_t FLAGS_LOW  = flags_t'((1 << `FLAG_WR_DEST) | (1 << `FLAG_WR_LOW) |
                                           (1 << `FLAG_EXECUTED));
  localparam flags_t FLAGS_HIGH = flags_t'((1 << `FLAG_WR_DEST) | (1 << `FLAG_EXECUTED));
  localparam flags_t FLAGS_SYS  = flags_t'((1 << `FLAG_EXECUTED) | (1 << `FLAG_EXCEPTION));
  localparam data_t  MOST_NEG   = data_t'({1'b1, {(`SIZE_DATA-1){1'b0}}});

  logic signed [2*`SIZE_DATA-1:0] prod_s;  // Full signed product
  logic        [2*`SIZE_DATA-1:0] prod_u;  // Full unsigned product
  logic  div_zero;                         // Divisor is zero
  logic  div_ovf;                          // Most negative by minus one
  data_t div_s_safe;                       // Signed divisor, never zero
  data_t div_u_safe;                       // Unsigned divisor, never zero
  data_t quot_s;
  data_t rem_s;
  data_t quot_u;
  data_t rem_u;

  assign prod_s = $signed(data1_i) * $signed(data2_i);  // Operands sign-extend to 64 bits
  assign prod_u = data1_i * data2_i;                    // Operands zero-extend

  assign div_zero = (data2_i == '0);
  assign div_ovf  = (data1_i == MOST_NEG) && (data2_i == '1);

  // A divisor of one makes the overflow case come out as dividend and zero
  assign div_s_safe = (div_zero || div_ovf) ? data_t'(1) : data2_i;
  assign div_u_safe = div_zero ? data_t'(1) : data2_i;

  assign quot_s = div_zero ? '1 : data_t'($signed(data1_i) / $signed(div_s_safe));
  assign rem_s  = div_zero ? data1_i : data_t'($signed(data1_i) % $signed(div_s_safe));
  assign quot_u = div_zero ? '1 : data1_i / div_u_safe;
  assign rem_u  = div_zero ? data1_i : data1_i % div_u_safe;

  always_comb begin : alu_select
    result_o = '0;                                  // Unsupported op gives zeros
    flags_o  = '0;
    case (opcode_i)
      `MULT_L: begin
        result_o = prod_s[`SIZE_DATA-1:0];
        flags_o  = FLAGS_LOW;
      end
      `MULT_H: begin
        result_o = prod_s[2*`SIZE_DATA-1:`SIZE_DATA];
        flags_o  = FLAGS_HIGH;
      end
      `MULTU_L: begin
        result_o = prod_u[`SIZE_DATA-1:0];
        flags_o  = FLAGS_LOW;
      end
      `MULTU_H: begin
        result_o = prod_u[2*`SIZE_DATA-1:`SIZE_DATA];
        flags_o  = FLAGS_HIGH;
      end
      `DIV_L: begin
        result_o = quot_s;
        flags_o  = FLAGS_LOW;
      end
      `DIV_H: begin
        result_o = rem_s;
        flags_o  = FLAGS_HIGH;
      end
      `DIVU_L: begin
        result_o = quot_u;
        flags_o  = FLAGS_LOW;
      end
      `DIVU_H: begin
        result_o = rem_u;
        flags_o  = FLAGS_HIGH;
      end
      `SYSCALL: begin
        result_o = '0;                              // Traps, writes nothing
        flags_o  = FLAGS_SYS;
      end
      default: begin
        result_o = '0;
        flags_o  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/complex_fu_pipe.sv
// Issue register, complex ALU and a fixed-depth chain of stage registers
// The whole chain moves as one unit while advance_i is high
`default_nettype none
`timescale 1ns/100ps

`include "fs_defs.svh"

module complex_fu_pipe (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 issue_valid_i,
  input  exec_pkg::issue_pkt_t issue_pkt_i,
  output logic                 issue_ready_o,
  input  logic                 advance_i,
  output logic                 out_valid_o,
  output exec_pkg::stage_pkt_t out_pkt_o
);
  import isa_pkg::*;
  import exec_pkg::*;

  logic       issue_valid_q;                   // Issue register holds an op
  issue_pkt_t issue_pkt_q;                     // Operands presented to the ALU
  data_t      alu_result;
  flags_t     alu_flags;
  stage_pkt_t alu_pkt;                         // ALU output joined with its tags

  logic       [`CALU_DEPTH-1:0] stage_valid_q;
  stage_pkt_t                   stage_pkt_q [`CALU_DEPTH];

  assign issue_ready_o = advance_i;            // Accept only when the chain moves

  // Issue register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_valid_q <= 1'b0;
    end else if (advance_i) begin
      issue_valid_q <= issue_valid_i;          // Bubble when nothing is offered
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i && issue_valid_i) begin
      issue_pkt_q <= issue_pkt_i;              // Payload only on a transfer
    end
  end

  complex_alu u_complex_alu (
    .opcode_i (issue_pkt_q.opcode),
    .data1_i  (issue_pkt_q.data1),
    .data2_i  (issue_pkt_q.data2),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  always_comb begin
    alu_pkt.result    = alu_result;
    alu_pkt.flags     = alu_flags;
    alu_pkt.phys_dest = issue_pkt_q.phys_dest;   // Tags bypass the ALU
    alu_pkt.al_idx    = issue_pkt_q.al_idx;
  end

  // Stage valid chain
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_valid_q <= '0;
    end else if (advance_i) begin
      stage_valid_q[0] <= issue_valid_q;
      for (int i = 1; i < `CALU_DEPTH; i++) begin
        stage_valid_q[i] <= stage_valid_q[i-1];
      end
    end
  end

  // Stage payload chain
  always_ff @(posedge clk) begin
    if (advance_i) begin
      stage_pkt_q[0] <= alu_pkt;
      for (int i = 1; i < `CALU_DEPTH; i++) begin
        stage_pkt_q[i] <= stage_pkt_q[i-1];
      end
    end
  end

  assign out_valid_o = stage_valid_q[`CALU_DEPTH-1];  // Last stage feeds writeback
  assign out_pkt_o   = stage_pkt_q[`CALU_DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/complex_writeback.sv
// Final output register of the complex lane
// Splits a finished op into writeback and active-list packets, holds under back-pressure
`default_nettype none
`timescale 1ns/100ps

`include "fs_defs.svh"

module complex_writeback (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  input  exec_pkg::stage_pkt_t in_pkt_i,
  output logic                 advance_o,
  input  logic                 wb_ready_i,
  output logic                 wb_valid_o,
  output exec_pkg::wb_pkt_t    wb_pkt_o,
  output exec_pkg::ctrl_pkt_t  ctrl_pkt_o
);
  import exec_pkg::*;

  logic      wb_valid_q;
  wb_pkt_t   wb_pkt_q;
  ctrl_pkt_t ctrl_pkt_q;
  wb_pkt_t   wb_next;                       // Split of the incoming stage packet
  ctrl_pkt_t ctrl_next;

  // Register free or draining this cycle
  assign advance_o = ~wb_valid_q | wb_ready_i;

  always_comb begin
    wb_next.phys_dest = in_pkt_i.phys_dest;
    wb_next.data      = in_pkt_i.flags[`FLAG_WR_DEST] ? in_pkt_i.result : '0;  // Syscall writes 0
    ctrl_next.al_idx  = in_pkt_i.al_idx;
    ctrl_next.flags   = in_pkt_i.flags;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
    end else if (advance_o) begin
      wb_valid_q <= in_valid_i;             // Empties when nothing arrives
    end
  end

  always_ff @(posedge clk) begin
    if (advance_o && in_valid_i) begin
      wb_pkt_q   <= wb_next;                // Held while stalled
      ctrl_pkt_q <= ctrl_next;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_pkt_o   = wb_pkt_q;
  assign ctrl_pkt_o = ctrl_pkt_q;

endmodule

`default_nettype wire

//--- hdl/complex_exec_lane.sv
// Complex execution lane top, pipeline plus writeback register
// Issue valid/ready in, writeback and active-list packets out
`default_nettype none
`timescale 1ns/100ps

module complex_exec_lane (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 issue_valid_i,
  input  exec_pkg::issue_pkt_t issue_pkt_i,
  output logic                 issue_ready_o,
  input  logic                 wb_ready_i,
  output logic                 wb_valid_o,
  output exec_pkg::wb_pkt_t    wb_pkt_o,
  output exec_pkg::ctrl_pkt_t  ctrl_pkt_o
);
  import exec_pkg::*;

  logic       pipe_valid;                   // Last stage holds an op
  stage_pkt_t pipe_pkt;
  logic       advance;                      // Whole pipeline moves

  complex_fu_pipe u_complex_fu_pipe (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_pkt_i   (issue_pkt_i),
    .issue_ready_o (issue_ready_o),
    .advance_i     (advance),
    .out_valid_o   (pipe_valid),
    .out_pkt_o     (pipe_pkt)
  );

  complex_writeback u_complex_writeback (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_valid_i (pipe_valid),
    .in_pkt_i   (pipe_pkt),
    .advance_o  (advance),
    .wb_ready_i (wb_ready_i),
    .wb_valid_o (wb_valid_o),
    .wb_pkt_o   (wb_pkt_o),
    .ctrl_pkt_o (ctrl_pkt_o)
  );

endmodule

`default_nettype wire

//--- testbench/complex_exec_lane_checker.sv
// Protocol assertions for the complex execution lane, bound to its top level
// The failure count is read by the testbench for its closing report
`default_nettype none
`timescale 1ns/100ps

`include "fs_defs.svh"

module complex_exec_lane_checker (
  input logic                clk,
  input logic                rst_n_i,
  input logic                issue_ready_i,
  input logic                wb_ready_i,
  input logic                wb_valid_i,
  input exec_pkg::wb_pkt_t   wb_pkt_i,
  input exec_pkg::ctrl_pkt_t ctrl_pkt_i
);
  import exec_pkg::*;

  int unsigned fail_count = 0;
  logic        held;                            // Result waiting under back-pressure

  assign held = wb_valid_i && !wb_ready_i;

  stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    held |=> wb_valid_i && $stable(wb_pkt_i) && $stable(ctrl_pkt_i))
    else begin
      fail_count++;
      $error("Writeback outputs changed during a stall");
    end

  empty_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !wb_valid_i)
    else begin
      fail_count++;
      $error("wb_valid_o high in the cycle after reset");
    end

  ready_vs_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_ready_i == !held)
    else begin
      fail_count++;
      $error("issue_ready_o does not follow the writeback stall");
    end

  exception_executed: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_valid_i && ctrl_pkt_i.flags[`FLAG_EXCEPTION] |-> ctrl_pkt_i.flags[`FLAG_EXECUTED])
    else begin
      fail_count++;
      $error("Exception flag set without executed flag");
    end

endmodule

bind complex_exec_lane complex_exec_lane_checker checker_inst (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .issue_ready_i (issue_ready_o),
  .wb_ready_i    (wb_ready_i),
  .wb_valid_i    (wb_valid_o),
  .wb_pkt_i      (wb_pkt_o),
  .ctrl_pkt_i    (ctrl_pkt_o)
);

`default_nettype wire

//--- testbench/tb_complex_exec_lane.sv
// Testbench for the complex execution lane
// Directed and random ops checked against a queue of expected results
`default_nettype none
`timescale 1ns/100ps

`include "fs_defs.svh"

module tb_complex_exec_lane;
  import isa_pkg::*;
  import exec_pkg::*;

  localparam int     TIMEOUT = 200;               // Cycles any wait may take
  localparam flags_t F_LOW   = 6'b011100;         // Write dest, write low, executed
  localparam flags_t F_HIGH  = 6'b010100;         // Write dest, executed
  localparam flags_t F_SYS   = 6'b000110;         // Executed, exception
  localparam data_t  MIN_NEG = 32'h8000_0000;

  typedef struct packed {
    data_t       data;
    flags_t      flags;
    phys_tag_t   phys_dest;
    al_idx_t     al_idx;
    int unsigned issue_cycle;                     // Cycle of the issue transfer
    int unsigned stall_mark;                      // Stalls seen up to the issue
  } expect_t;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        issue_valid_i;
  issue_pkt_t  issue_pkt_i;
  logic        issue_ready_o;
  logic        wb_ready_i;
  logic        wb_valid_o;
  wb_pkt_t     wb_pkt_o;
  ctrl_pkt_t   ctrl_pkt_o;

  expect_t     expq[$];                           // Ops in flight, issue order
  int unsigned errors = 0;
  int unsigned cycle = 0;
  int unsigned stalls = 0;
  logic        ready_random = 1'b0;               // Random back-pressure on
  logic        timed_out = 1'b0;                  // A wait ran out of cycles

  complex_exec_lane complex_exec_lane_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_pkt_i   (issue_pkt_i),
    .issue_ready_o (issue_ready_o),
    .wb_ready_i    (wb_ready_i),
    .wb_valid_o    (wb_valid_o),
    .wb_pkt_o      (wb_pkt_o),
    .ctrl_pkt_o    (ctrl_pkt_o)
  );

  always #4 clk = ~clk;

  // Expected data and flags, worked out in 64 bits so no divide can overflow
  function automatic expect_t model_op(issue_pkt_t op);
    expect_t     e;
    longint      sa;
    longint      sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] sprod;
    logic [63:0] uprod;
    logic [63:0] sq;
    logic [63:0] sr;
    logic [63:0] uq;
    logic [63:0] ur;
    e     = '0;
    sa    = longint'($signed(op.data1));
    sb    = longint'($signed(op.data2));
    ua    = {32'd0, op.data1};
    ub    = {32'd0, op.data2};
    sprod = sa * sb;
    uprod = ua * ub;
    if (op.data2 == '0) begin                     // Quotient all ones, remainder is dividend
      sq = '1;
      sr = ua;
      uq = '1;
      ur = ua;
    end else begin
      sq = sa / sb;
      sr = sa % sb;
      uq = ua / ub;
      ur = ua % ub;
    end
    e.phys_dest = op.phys_dest;
    e.al_idx    = op.al_idx;
    case (op.opcode)
      `MULT_L:  {e.flags, e.data} = {F_LOW, sprod[31:0]};
      `MULT_H:  {e.flags, e.data} = {F_HIGH, sprod[63:32]};
      `MULTU_L: {e.flags, e.data} = {F_LOW, uprod[31:0]};
      `MULTU_H: {e.flags, e.data} = {F_HIGH, uprod[63:32]};
      `DIV_L:   {e.flags, e.data} = {F_LOW, sq[31:0]};
      `DIV_H:   {e.flags, e.data} = {F_HIGH, sr[31:0]};
      `DIVU_L:  {e.flags, e.data} = {F_LOW, uq[31:0]};
      `DIVU_H:  {e.flags, e.data} = {F_HIGH, ur[31:0]};
      `SYSCALL: {e.flags, e.data} = {F_SYS, 32'd0};
      default:  {e.flags, e.data} = '0;
    endcase
    if (!e.flags[`FLAG_WR_DEST]) e.data = '0;     // Nothing written back
    return e;
  endfunction

  // Corner values often, random words otherwise
  function automatic data_t pick_operand();
    case ($urandom % 8)
      0: return '0;
      1: return MIN_NEG;
      2: return '1;
      3: return data_t'(1);
      default: return data_t'($urandom);
    endcase
  endfunction

  // Later waits are skipped once one has run out
  task automatic note_timeout(string what);
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  task automatic report_value(string what, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
  endtask

  // Offer one op and hold it until an edge with issue_ready_o high
  task automatic send_op(opcode_t opc, data_t a, data_t b);
    int   waited;
    logic taken;
    if (timed_out) return;
    issue_valid_i         = 1'b1;
    issue_pkt_i.opcode    = opc;
    issue_pkt_i.data1     = a;
    issue_pkt_i.data2     = b;
    issue_pkt_i.immd      = imm_t'($urandom);
    issue_pkt_i.phys_dest = phys_tag_t'($urandom);
    issue_pkt_i.al_idx    = al_idx_t'($urandom);
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < TIMEOUT) begin
      @(posedge clk);
      taken = issue_ready_o;                      // Value before the edge settles
      waited++;
    end
    if (!taken) note_timeout("issue_ready_o stayed low");
    #1;
  endtask

  task automatic idle_cycle();
    if (timed_out) return;
    issue_valid_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    int waited;
    if (timed_out) return;
    issue_valid_i = 1'b0;
    waited = 0;
    while (expq.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expq.size() != 0) note_timeout("results still outstanding");
  endtask

  task automatic check_result();
    expect_t e;
    assert (expq.size() != 0) else begin
      errors++;
      $display("Fail at %0t ns: writeback with no op outstanding", $time);
    end
    if (expq.size() != 0) begin
      e = expq.pop_front();
      assert (wb_pkt_o.data == e.data) else report_value("data", wb_pkt_o.data, e.data);
      assert (wb_pkt_o.phys_dest == e.phys_dest)
        else report_value("phys_dest", 32'(wb_pkt_o.phys_dest), 32'(e.phys_dest));
      assert (ctrl_pkt_o.al_idx == e.al_idx)
        else report_value("al_idx", 32'(ctrl_pkt_o.al_idx), 32'(e.al_idx));
      assert (ctrl_pkt_o.flags == e.flags)
        else report_value("flags", 32'(ctrl_pkt_o.flags), 32'(e.flags));
      if (stalls == e.stall_mark) begin           // No stall, so the latency is fixed
        assert (cycle - e.issue_cycle == `CALU_DEPTH + 2)
          else report_value("latency", cycle - e.issue_cycle, `CALU_DEPTH + 2);
      end
    end
  endtask

  // Transfers seen at each rising edge, before the DUT registers update
  always @(posedge clk) begin
    cycle++;
    if (rst_n_i) begin
      if (wb_valid_o && !wb_ready_i) stalls++;
      if (issue_valid_i && issue_ready_o) begin
        expq.push_back(model_op(issue_pkt_i));
        expq[$].issue_cycle = cycle;
        expq[$].stall_mark  = stalls;
      end
      if (wb_valid_o && wb_ready_i) check_result();
    end
  end

  always @(posedge clk) begin
    #1;
    wb_ready_i = ready_random ? ($urandom % 4 != 0) : 1'b1;  // Low about one cycle in four
  end

  initial begin : stimulus
    opcode_t     bad_ops [4];
    int unsigned checker_fails;
    bad_ops = '{8'h00, 8'h3F, 8'h49, 8'hFF};
    void'($urandom(32'hb7536a4a));
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_pkt_i   = '0;
    wb_ready_i    = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    assert (!wb_valid_o) else report_value("wb_valid_o after reset", 32'(wb_valid_o), 0);
    // Back-to-back multiplies, no back-pressure
    repeat (40) send_op(opcode_t'(`MULT_L + $urandom % 4), pick_operand(), pick_operand());
    drain();
    // Divide corners first, then random divides and remainders
    send_op(`DIV_L, MIN_NEG, '1);
    send_op(`DIV_H, MIN_NEG, '1);
    send_op(`DIV_L, data_t'(-7), '0);
    send_op(`DIVU_H, data_t'(12345), '0);
    repeat (60) send_op(opcode_t'(`DIV_L + $urandom % 4), pick_operand(), pick_operand());
    drain();
    repeat (4) send_op(`SYSCALL, data_t'($urandom), data_t'($urandom));
    foreach (bad_ops[i]) send_op(bad_ops[i], data_t'($urandom), data_t'($urandom));
    drain();
    // Mixed ops under random back-pressure, with issue bubbles
    ready_random = 1'b1;
    for (int n = 0; n < 150; n++) begin
      if ($urandom % 6 == 0) idle_cycle();
      send_op(opcode_t'(`MULT_L + $urandom % 10), pick_operand(), pick_operand());
    end
    drain();
    ready_random  = 1'b0;
    checker_fails = complex_exec_lane_inst.checker_inst.fail_count;
    $display("Errors: %0d result checks, %0d protocol assertions", errors, checker_fails);
    if (!timed_out && errors == 0 && checker_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/complex_alu.sv
hdl/complex_fu_pipe.sv
hdl/complex_writeback.sv
hdl/complex_exec_lane.sv
testbench/complex_exec_lane_checker.sv
testbench/tb_complex_exec_lane.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_complex_exec_lane
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
